// File: include/switch_config.svh
// Switch configuration macros: port count, header delay, queue sizes, gap and MAC constants
`ifndef SWITCH_CONFIG_SVH
`define SWITCH_CONFIG_SVH

`define SW_NUM_PORTS 4                // Ports on the switch

// Receive path
`define SW_HEADER_DELAY 14            // 8 preamble bytes + 6 destination bytes
`define SW_SFD 8'hd5                  // Start-of-frame delimiter

// Queues
`define SW_QUEUE_DEPTH 128            // Entries per input/output pair
`define SW_MAX_FRAME 64               // Largest frame on the wire, free space needed at first byte

// Transmit path
`define SW_IPG 12                     // Interpacket gap in cycles

// Addressing
`define SW_OUI 24'hfa610e             // Organisation identifier, upper 24 bits
`define SW_MID 16'h0300               // Middle field of the primary addresses
`define SW_MCAST_BIT 24'h010000       // Group bit within the upper 24 bits
`define SW_BROADCAST 48'hffff_ffff_ffff

`endif

// File: verilog/switchPkg.sv
// Shared switch types: data byte, MAC address, port index, port mask, queue entry
`include "switch_config.svh"

package switchPkg;

  typedef logic [7:0] byteT;                      // One stream byte
  typedef logic [47:0] macAddrT;                  // Ethernet address
  typedef logic [1:0] portIdxT;                   // Port number 0..3
  typedef logic [`SW_NUM_PORTS-1:0] portMaskT;    // Bit p set selects port p

  // One stored byte with its frame boundary flags
  typedef struct packed {
    logic first;   // First byte of a frame (preamble start)
    logic last;    // Last byte of a frame
    byteT data;
  } queueEntryT;

endpackage

// File: verilog/frameReceiver.sv
// Receive stage of one port: header delay line, start-of-frame detection, destination MAC capture
`timescale 1ns/1ps
`include "switch_config.svh"

module frameReceiver (
  input  logic               RxClk,
  input  logic               arstN,
  input  logic               rxValid,    // High for every byte of a frame
  input  switchPkg::byteT    rxData,
  output logic               byteValid,  // Delayed stream toward filter and queues
  output logic               byteFirst,
  output logic               byteLast,
  output switchPkg::byteT    byteData,
  output switchPkg::macAddrT destMac     // Valid from first delayed byte to next delimiter
);
  import switchPkg::*;

  localparam int Delay = `SW_HEADER_DELAY;

  typedef enum logic {
    Idle,     // Waiting for the delimiter
    Header    // Collecting destination bytes
  } rxStateT;

  byteT           dataDly [Delay];   // Index 0 holds the newest byte
  logic [Delay:0] validDly;          // One stage longer, to see the edge at the output
  rxStateT        state;
  logic           sfdSeen;           // Delimiter of the current frame already found
  logic [2:0]     hdrCnt;            // Destination byte 0..5
  macAddrT        macReg;

  // Valid line
  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      validDly <= '0;
    end else begin
      validDly <= {validDly[Delay-1:0], rxValid};
    end
  end

  // Data line, same length as the valid line up to the output tap
  always_ff @(posedge RxClk) begin
    dataDly[0] <= rxData;
    for (int i = 1; i < Delay; i++) begin
      dataDly[i] <= dataDly[i-1];
    end
  end

  // Delimiter search and header byte count
  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      state   <= Idle;
      hdrCnt  <= '0;
      sfdSeen <= 1'b0;
    end else if (state == Idle) begin
      hdrCnt <= '0;
      if (!rxValid) begin
        sfdSeen <= 1'b0;                  // Between frames, look for the next delimiter
      end else if (rxData == `SW_SFD && !sfdSeen) begin
        state   <= Header;                // Next byte is destination MSB
        sfdSeen <= 1'b1;                  // Later 8'hd5 bytes are payload
      end
    end else begin
      if (!rxValid) begin
        state   <= Idle;                  // Runt frame, give up on it
        sfdSeen <= 1'b0;
      end else begin
        hdrCnt <= hdrCnt + 3'd1;
        if (hdrCnt == 3'd5) begin
          state <= Idle;                  // Sixth byte taken
        end
      end
    end
  end

  // Destination shifts in MSB first and then holds
  always_ff @(posedge RxClk) begin
    if (state == Header && rxValid) begin
      macReg <= {macReg[39:0], rxData};
    end
  end

  // Boundaries from valid edges at the line output
  assign byteValid = validDly[Delay-1];
  assign byteData  = dataDly[Delay-1];
  assign byteFirst = validDly[Delay-1] & ~validDly[Delay];
  assign byteLast  = validDly[Delay-1] & ~validDly[Delay-2];   // Next one is not valid
  assign destMac   = macReg;

  // A frame spans at least two bytes, so its edges never coincide
  assert property (@(posedge RxClk) disable iff (!arstN) !(byteFirst && byteLast))
    else $error("frameReceiver: first and last byte flags high together");

endmodule

// File: verilog/destFilter.sv
// Forwarding decision of one input: broadcast, multicast, primary match and flooding per port
`timescale 1ns/1ps
`include "switch_config.svh"

module destFilter #(
  parameter int ownIndex = 0            // Input port this filter belongs to
) (
  input  switchPkg::macAddrT destMac,
  input  switchPkg::portMaskT portActive,
  input  logic [3:0]         boardId,
  output switchPkg::portMaskT fwdMask    // Bit p forwards the frame to output p
);
  import switchPkg::*;

  localparam int NumPorts = `SW_NUM_PORTS;
  localparam logic [23:0] McastOui = `SW_OUI | `SW_MCAST_BIT;

  macAddrT  primary [NumPorts];   // OUI, middle field, board, port
  portMaskT match;                // Destination matches primary of port p
  logic     isBroadcast;
  logic     isMulticast;
  logic     noMatch;

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      primary[p] = {`SW_OUI, `SW_MID, boardId, 4'(p)};
      // Bit 40 is the group bit; when set, the low byte is a wildcard
      match[p] = (p != ownIndex) &&
                 (destMac[47:41] == primary[p][47:41]) &&
                 (destMac[39:8] == primary[p][39:8]) &&
                 ((destMac[7:0] == primary[p][7:0]) || destMac[40]);
    end
  end

  assign isBroadcast = (destMac == `SW_BROADCAST);
  assign isMulticast = (destMac[47:24] == McastOui) && (destMac[7:0] == 8'hff);
  assign noMatch     = ~|match;   // Unknown unicast, flood

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      fwdMask[p] = portActive[p] && (p != ownIndex) &&
                   (isBroadcast || isMulticast || match[p] || noMatch);
    end
  end

endmodule

// File: verilog/pairQueue.sv
// Store-and-forward queue for one input/output pair with whole-frame drop at the first byte
`timescale 1ns/1ps
`include "switch_config.svh"

module pairQueue (
  input  logic                  RxClk,
  input  logic                  arstN,
  input  logic                  fwd,          // Filter selects this output
  input  logic                  byteValid,
  input  logic                  byteFirst,
  input  logic                  byteLast,
  input  switchPkg::byteT       byteData,
  input  logic                  pop,          // From the output scheduler
  output switchPkg::queueEntryT headEntry,
  output logic                  frameReady    // At least one whole frame stored
);
  import switchPkg::*;

  localparam int Depth = `SW_QUEUE_DEPTH;
  localparam int AddrW = $clog2(Depth);

  typedef logic [AddrW-1:0] ptrT;
  typedef logic [AddrW:0] cntT;

  queueEntryT mem [Depth];   // Circular buffer
  ptrT        wrPtr;
  ptrT        rdPtr;
  cntT        count;         // Entries in use
  cntT        frameCnt;      // Complete frames in use
  logic       dropFrame;     // Current input frame is discarded
  logic       roomLow;
  logic       dropNow;
  logic       wrEn;
  logic       popLast;

  assign roomLow = count > cntT'(Depth - `SW_MAX_FRAME);   // Less than one frame free
  assign dropNow = byteFirst ? roomLow : dropFrame;        // Decision applies to first byte too
  assign wrEn    = fwd & byteValid & ~dropNow;
  assign popLast = pop & headEntry.last;

  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      count     <= '0;
      frameCnt  <= '0;
      dropFrame <= 1'b0;
    end else begin
      if (byteValid && byteFirst) begin
        dropFrame <= roomLow;
      end
      if (wrEn) begin
        wrPtr <= wrPtr + 1'b1;   // Wraps, depth is a power of two
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count    <= count + cntT'(wrEn) - cntT'(pop);
      frameCnt <= frameCnt + cntT'(wrEn & byteLast) - cntT'(popLast);
    end
  end

  always_ff @(posedge RxClk) begin
    if (wrEn) begin
      mem[wrPtr] <= '{first: byteFirst, last: byteLast, data: byteData};
    end
  end

  assign headEntry  = mem[rdPtr];
  assign frameReady = (frameCnt != '0);

  // Room reserved at the first byte must cover the whole frame
  assert property (@(posedge RxClk) disable iff (!arstN) wrEn |-> count < cntT'(Depth))
    else $error("pairQueue: write into a full queue");

  // Scheduler only pops a stored frame
  assert property (@(posedge RxClk) disable iff (!arstN) pop |-> count != '0)
    else $error("pairQueue: pop from an empty queue");

endmodule

// File: verilog/txScheduler.sv
// Transmit stage of one output: round-robin frame selection over the peers, gap timing, byte stream
`timescale 1ns/1ps
`include "switch_config.svh"

module txScheduler #(
  parameter int ownIndex = 0                                // Output port served
) (
  input  logic                   RxClk,
  input  logic                   arstN,
  input  logic                   recvReady,                 // Client can take a byte
  input  logic [`SW_NUM_PORTS-2:0] frameReady,              // Bit k for peer k
  input  switchPkg::queueEntryT  headEntry [`SW_NUM_PORTS-1],
  output logic [`SW_NUM_PORTS-2:0] pop,
  output logic                   txEn,
  output switchPkg::byteT        txData,
  output switchPkg::portIdxT     txSrc                      // Current or most recent source
);
  import switchPkg::*;

  localparam int NumPorts = `SW_NUM_PORTS;
  localparam int NumPeers = NumPorts - 1;
  localparam int GapW = $clog2(`SW_IPG + 1);

  typedef logic [1:0] peerT;        // Peer k is port (ownIndex+1+k) mod 4
  typedef logic [GapW-1:0] gapT;

  peerT cur;                        // Peer being sent, or last one served
  peerT pick;
  logic found;
  logic sending;
  logic startFrame;
  logic endFrame;
  gapT  gapCnt;

  // Scan starts right after the last peer served, ends on it
  always_comb begin
    found = 1'b0;
    pick  = cur;
    for (int i = 1; i <= NumPeers; i++) begin
      if (!found && frameReady[(int'(cur) + i) % NumPeers]) begin
        found = 1'b1;
        pick  = peerT'((int'(cur) + i) % NumPeers);
      end
    end
  end

  assign startFrame = !sending && (gapCnt == '0) && found;
  assign endFrame   = sending && recvReady && headEntry[cur].last;

  // One byte per ready cycle
  assign txEn   = sending & recvReady;
  assign txData = headEntry[cur].data;

  always_comb begin
    pop      = '0;
    pop[cur] = sending & recvReady;
  end

  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      sending <= 1'b0;
      cur     <= peerT'(NumPeers - 1);    // First scan begins at peer 0
      gapCnt  <= '0;
      txSrc   <= '0;
    end else if (startFrame) begin
      sending <= 1'b1;
      cur     <= pick;
      txSrc   <= portIdxT'((ownIndex + 1 + int'(pick)) % NumPorts);
    end else if (endFrame) begin
      sending <= 1'b0;
      gapCnt  <= gapT'(`SW_IPG);          // Gap before the next selection
    end else if (gapCnt != '0) begin
      gapCnt <= gapCnt - 1'b1;
    end
  end

  // Only one peer at a time, and only one that holds a whole frame
  assert property (@(posedge RxClk) disable iff (!arstN)
                   $onehot0(pop) && ((pop & ~frameReady) == '0))
    else $error("txScheduler: pop of a queue without a stored frame");

  // A selected queue must present the start of a stored frame
  assert property (@(posedge RxClk) disable iff (!arstN) startFrame |=> headEntry[cur].first)
    else $error("txScheduler: selected queue head is not a first byte");

endmodule

// File: verilog/ethSwitchTop.sv
// Four-port switch top: receivers, filters, pair queues and output schedulers
`timescale 1ns/1ps
`include "switch_config.svh"

module ethSwitchTop (
  input  logic                     RxClk,
  input  logic                     arstN,
  input  logic [`SW_NUM_PORTS-1:0] rxValid,
  input  switchPkg::byteT          rxData [`SW_NUM_PORTS],
  input  switchPkg::portMaskT      portActive,   // Link up per port
  input  logic [3:0]               boardId,      // Goes into the primary addresses
  input  logic [`SW_NUM_PORTS-1:0] recvReady,
  output logic [`SW_NUM_PORTS-1:0] txEn,
  output switchPkg::byteT          txData [`SW_NUM_PORTS],
  output switchPkg::portIdxT       txSrc [`SW_NUM_PORTS]
);
  import switchPkg::*;

  localparam int NumPorts = `SW_NUM_PORTS;

  // Per input
  wire [NumPorts-1:0] byteValid;
  wire [NumPorts-1:0] byteFirst;
  wire [NumPorts-1:0] byteLast;
  byteT               byteData [NumPorts];
  macAddrT            destMac [NumPorts];
  portMaskT           fwdMask [NumPorts];

  // Per output, indexed by peer
  queueEntryT         qHead [NumPorts][NumPorts-1];
  wire [NumPorts-2:0] qReady [NumPorts];
  wire [NumPorts-2:0] qPop [NumPorts];

  for (genvar p = 0; p < NumPorts; p++) begin : portGen
    frameReceiver rxU (
      .RxClk(RxClk), .arstN(arstN),
      .rxValid(rxValid[p]), .rxData(rxData[p]),
      .byteValid(byteValid[p]), .byteFirst(byteFirst[p]), .byteLast(byteLast[p]),
      .byteData(byteData[p]), .destMac(destMac[p])
    );

    destFilter #(.ownIndex(p)) filtU (
      .destMac(destMac[p]), .portActive(portActive), .boardId(boardId),
      .fwdMask(fwdMask[p])
    );

    txScheduler #(.ownIndex(p)) schedU (
      .RxClk(RxClk), .arstN(arstN), .recvReady(recvReady[p]),
      .frameReady(qReady[p]), .headEntry(qHead[p]), .pop(qPop[p]),
      .txEn(txEn[p]), .txData(txData[p]), .txSrc(txSrc[p])
    );

    // Queue for peer k holds frames from input (p+1+k) mod 4 toward output p
    for (genvar k = 0; k < NumPorts - 1; k++) begin : peerGen
      localparam int srcPort = (p + 1 + k) % NumPorts;

      pairQueue qU (
        .RxClk(RxClk), .arstN(arstN),
        .fwd(fwdMask[srcPort][p]),
        .byteValid(byteValid[srcPort]), .byteFirst(byteFirst[srcPort]),
        .byteLast(byteLast[srcPort]), .byteData(byteData[srcPort]),
        .pop(qPop[p][k]),
        .headEntry(qHead[p][k]), .frameReady(qReady[p][k])
      );
    end
  end

endmodule

// File: verification/tbEthSwitch.sv
// Testbench for the four-port switch: golden-file stimulus, frame builder, output monitor, timeout
`timescale 1ns/1ps
`include "switch_config.svh"

module tbEthSwitch;

  localparam int NumPorts = `SW_NUM_PORTS;
  localparam int MaxRec = 64;              // Records in the golden file
  localparam int HdrLen = 22;              // Preamble, SFD, two addresses, type
  localparam int IdleGap = 16;             // Idle cycles after each input frame
  localparam int SettleCycles = 40;        // Watch for stray frames after a test
  localparam logic [31:0] Seed = 32'hd2e73e1c;

  logic       RxClk;
  logic       arstN;
  logic [3:0] rxValid;
  logic [7:0] rxData [NumPorts];
  logic [3:0] portActive;
  logic [3:0] boardId;
  logic [3:0] recvReady = 4'hf;
  logic [3:0] txEn;
  logic [7:0] txData [NumPorts];
  logic [1:0] txSrc [NumPorts];

  logic [71:0] golden [MaxRec];            // kind, port, dest, len, ready, active
  logic [7:0]  frameMem [8192];            // Copy of every frame sent
  int          frameBase [MaxRec];
  int          frameLen [MaxRec];
  int          nFrames;
  int          memTop;
  int          lastFrame [NumPorts];       // Latest frame per input
  int          expPort [MaxRec];
  int          expSrc [MaxRec];
  int          expLen [MaxRec];
  int          expFrame [MaxRec];
  int          nExp;
  int          delivered;

  int          nextExp [NumPorts];         // Monitor state per output
  int          curExp [NumPorts];
  int          bytePos [NumPorts];
  int          idleRun [NumPorts];
  logic        inFrame [NumPorts];
  logic        sentAny [NumPorts];

  logic [3:0]  readyBase;
  logic [3:0]  toggleMask;                 // Ports whose ready follows the LFSR
  logic [31:0] payLfsr;
  logic [31:0] readyLfsr;
  int          cycles;
  int          cycleLimit;

  ethSwitchTop uut (
    .RxClk(RxClk), .arstN(arstN), .rxValid(rxValid), .rxData(rxData),
    .portActive(portActive), .boardId(boardId), .recvReady(recvReady),
    .txEn(txEn), .txData(txData), .txSrc(txSrc)
  );

  initial RxClk = 1'b0;
  always #4 RxClk = ~RxClk;                // 8 ns period

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic nextPayloadByte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      payLfsr = lfsrStep(payLfsr);
      b = {b[6:0], payLfsr[0]};            // One step per bit
    end
  endtask

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string sig, input int port, input int expV, input int gotV);
    stopWithFailure($sformatf("CHECK FAILED at %0t: %s[%0d] expected %0h, got %0h",
                              $time, sig, port, expV, gotV));
  endtask

  // Ready level per output, random bit for toggled ports
  always @(negedge RxClk) begin
    readyLfsr = lfsrStep(readyLfsr);
    recvReady = (readyBase & ~toggleMask) | (toggleMask & {4{readyLfsr[0]}});
  end

  always @(posedge RxClk) begin
    cycles = cycles + 1;
    if (cycleLimit > 0 && cycles > cycleLimit) begin
      stopWithFailure($sformatf("Timeout: run exceeded %0d cycles, %0d of %0d frames delivered",
                                cycleLimit, delivered, nExp));
    end
  end

  // Output monitor, samples values settled since the falling edge
  always @(posedge RxClk) begin
    if (arstN) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (txEn[p]) begin
          assert (recvReady[p]) else   // No byte goes out while the client is not ready
            reportMismatch("txEn", p, 0, int'(txEn[p]));
          if (!inFrame[p]) begin
            while (nextExp[p] < nExp && expPort[nextExp[p]] != p) begin
              nextExp[p] = nextExp[p] + 1;
            end
            assert (nextExp[p] < nExp) else
              stopWithFailure($sformatf("Output port %0d sent a frame that was not expected at %0t",
                                        p, $time));
            assert (!sentAny[p] || idleRun[p] >= `SW_IPG) else
              stopWithFailure($sformatf("Output port %0d gap of %0d cycles is too short at %0t",
                                        p, idleRun[p], $time));
            curExp[p]  = nextExp[p];
            nextExp[p] = nextExp[p] + 1;
            inFrame[p] = 1'b1;
            sentAny[p] = 1'b1;
            bytePos[p] = 0;
          end
          assert (int'(txSrc[p]) == expSrc[curExp[p]]) else
            reportMismatch("txSrc", p, expSrc[curExp[p]], int'(txSrc[p]));
          assert (txData[p] == frameMem[frameBase[expFrame[curExp[p]]] + bytePos[p]]) else
            reportMismatch("txData", p,
                           int'(frameMem[frameBase[expFrame[curExp[p]]] + bytePos[p]]),
                           int'(txData[p]));
          bytePos[p] = bytePos[p] + 1;
          if (bytePos[p] == expLen[curExp[p]]) begin   // Frame complete
            inFrame[p] = 1'b0;
            idleRun[p] = 0;
            delivered  = delivered + 1;
          end
        end else if (!inFrame[p]) begin
          idleRun[p] = idleRun[p] + 1;
        end
      end
    end
  end

  // Build frame copy, then drive it one byte per cycle
  task automatic sendFrame(input int port, input logic [47:0] dest, input int payLen);
    int base;
    logic [7:0] b;
    base = memTop;
    for (int i = 0; i < 7; i++) frameMem[base + i] = 8'h55;
    frameMem[base + 7] = `SW_SFD;
    for (int i = 0; i < 6; i++) frameMem[base + 8 + i] = dest[47 - 8*i -: 8];   // MSB first
    for (int i = 0; i < 5; i++) frameMem[base + 14 + i] = (i == 0) ? 8'h02 : 8'h00;
    frameMem[base + 19] = 8'(port);        // Source tagged with input port
    frameMem[base + 20] = 8'h08;
    frameMem[base + 21] = 8'h00;
    for (int i = 0; i < payLen; i++) begin
      nextPayloadByte(b);
      frameMem[base + HdrLen + i] = b;
    end
    frameBase[nFrames] = base;
    frameLen[nFrames]  = HdrLen + payLen;
    lastFrame[port]    = nFrames;
    nFrames = nFrames + 1;
    memTop  = base + HdrLen + payLen;
    for (int i = 0; i < HdrLen + payLen; i++) begin
      @(negedge RxClk);
      rxValid[port] = 1'b1;
      rxData[port]  = frameMem[base + i];
    end
    @(negedge RxClk);
    rxValid[port] = 1'b0;
    rxData[port]  = '0;
    repeat (IdleGap - 1) @(negedge RxClk);
  endtask

  task automatic addExpect(input int outPort, input int src, input int payLen);
    if (lastFrame[src] < 0 || frameLen[lastFrame[src]] != HdrLen + payLen) begin
      stopWithFailure("Golden file expects a frame that the source port did not send");
    end
    expPort[nExp]  = outPort;
    expSrc[nExp]   = src;
    expLen[nExp]   = HdrLen + payLen;
    expFrame[nExp] = lastFrame[src];
    nExp = nExp + 1;
  endtask

  task automatic waitDelivered();
    while (delivered != nExp) @(negedge RxClk);
    repeat (SettleCycles) @(negedge RxClk);     // Extra frames would show here
  endtask

  // Limit from input lengths, output lengths with gaps, and settle time
  function automatic int computeLimit();
    int sum;
    int len;
    sum = 16;
    for (int i = 0; i < MaxRec; i++) begin
      len = HdrLen + int'(golden[i][15:8]);
      case (golden[i][71:68])
        4'h1: sum += len + IdleGap + `SW_HEADER_DELAY;
        4'h2: sum += 2 * len + `SW_IPG + 1;      // Toggled ready halves throughput
        4'h4: sum += SettleCycles;
        default: sum += 0;
      endcase
    end
    return 2 * sum;
  endfunction

  initial begin
    logic [3:0] kind;
    int port;
    logic stop;
    arstN = 1'b0;
    rxValid = '0;
    for (int p = 0; p < NumPorts; p++) begin
      rxData[p]    = '0;
      lastFrame[p] = -1;
      nextExp[p]   = 0;
      curExp[p]    = 0;
      bytePos[p]   = 0;
      idleRun[p]   = 0;
      inFrame[p]   = 1'b0;
      sentAny[p]   = 1'b0;
    end
    portActive = 4'hf;
    boardId    = 4'h5;
    readyBase  = 4'hf;
    toggleMask = 4'h0;
    payLfsr    = Seed;
    readyLfsr  = Seed;
    nFrames = 0;
    memTop = 0;
    nExp = 0;
    delivered = 0;
    cycles = 0;
    cycleLimit = 0;
    stop = 1'b0;
    for (int i = 0; i < MaxRec; i++) golden[i] = '0;
    $readmemh("verification/switch_golden.txt", golden);
    cycleLimit = computeLimit();

    repeat (16) @(posedge RxClk);
    @(negedge RxClk);
    arstN = 1'b1;
    for (int p = 0; p < NumPorts; p++) begin
      assert (txEn[p] == 1'b0) else reportMismatch("txEn", p, 0, int'(txEn[p]));
      assert (txSrc[p] == 2'd0) else reportMismatch("txSrc", p, 0, int'(txSrc[p]));
    end

    for (int i = 0; i < MaxRec && !stop; i++) begin
      kind = golden[i][71:68];
      port = int'(golden[i][67:64]);
      case (kind)
        4'h1: sendFrame(port, golden[i][63:16], int'(golden[i][15:8]));
        4'h2: addExpect(port, int'(golden[i][3:0]), int'(golden[i][15:8]));
        4'h3: begin
          @(negedge RxClk);
          toggleMask = golden[i][67:64];
          readyBase  = golden[i][7:4];
          portActive = golden[i][3:0];
        end
        4'h4: waitDelivered();
        default: stop = 1'b1;                    // End of records
      endcase
    end

    if (delivered == nExp && nExp > 0) begin
      $display("Verification passed");
    end else begin
      stopWithFailure($sformatf("Only %0d of %0d expected frames were delivered", delivered, nExp));
    end
    $finish;
  end

endmodule

// File: verification/switch_golden.txt
// kind_port_destination_payloadLen_ready_active, hex, one record per line
// kind 1 send (port=input), 2 expect (port=output, last digit=source), 3 config (port=toggle mask), 4 wait
3_0_000000000000_00_f_f
// Unicast to port 2 primary address
1_0_fa610e030052_0a_0_0
2_2_000000000000_0a_0_0
4_0_000000000000_00_0_0
// Broadcast from port 0 to all others
1_0_ffffffffffff_14_0_0
2_1_000000000000_14_0_0
2_2_000000000000_14_0_0
2_3_000000000000_14_0_0
4_0_000000000000_00_0_0
// Multicast from port 3 with port 2 inactive
3_0_000000000000_00_f_b
1_3_fb610e0300ff_10_0_0
2_0_000000000000_10_0_3
2_1_000000000000_10_0_3
4_0_000000000000_00_0_0
// Unknown unicast from port 1 floods
3_0_000000000000_00_f_f
1_1_fa610e030059_18_0_0
2_0_000000000000_18_0_1
2_2_000000000000_18_0_1
2_3_000000000000_18_0_1
4_0_000000000000_00_0_0
// Port 3 held off, four 64-byte frames queue, fifth is dropped
3_0_000000000000_00_7_f
1_0_fa610e030053_2a_0_0
2_3_000000000000_2a_0_0
1_1_fa610e030053_2a_0_0
2_3_000000000000_2a_0_1
1_0_fa610e030053_2a_0_0
2_3_000000000000_2a_0_0
1_1_fa610e030053_2a_0_0
2_3_000000000000_2a_0_1
1_0_fa610e030053_2a_0_0
3_0_000000000000_00_f_f
4_0_000000000000_00_0_0
// Port 2 ready toggles randomly
3_4_000000000000_00_f_f
1_0_fa610e030052_1e_0_0
2_2_000000000000_1e_0_0
1_1_fa610e030052_19_0_0
2_2_000000000000_19_0_1
4_0_000000000000_00_0_0
3_0_000000000000_00_f_f

// File: tb.f
+incdir+include
verilog/switchPkg.sv
verilog/frameReceiver.sv
verilog/destFilter.sv
verilog/pairQueue.sv
verilog/txScheduler.sv
verilog/ethSwitchTop.sv
verification/tbEthSwitch.sv

// File: run.sh
#!/bin/sh
# Compile and run the switch testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tbEthSwitch -o simTb
out=$(./obj_dir/simTb || true)
echo "$out"
echo "$out" | grep -q "^Verification passed$"
